// ==== logic/frv_pkg.sv ====
//--------------------------------------------------------------------------
// Retire-end shared definitions
// Data widths, functional-unit bit positions, micro-op encodings,
// machine-mode CSR addresses and trap cause codes
//--------------------------------------------------------------------------
package frv_pkg;

    localparam int XLEN = 32;                     // Data width
    localparam int XL   = XLEN - 1;               // Top bit index

    //----------------------------------------------------------------------
    // Functional unit one-hot positions
    localparam int P_FU_ALU = 0;
    localparam int P_FU_MUL = 1;
    localparam int P_FU_LSU = 2;
    localparam int P_FU_CFU = 3;
    localparam int P_FU_CSR = 4;

    localparam int LSU_LOAD = 0;                  // Load flag, LSU micro-op

    localparam int CSR_READ  = 0;                 // CSR micro-op flag bits
    localparam int CSR_WRITE = 1;
    localparam int CSR_SET   = 2;
    localparam int CSR_CLEAR = 3;

    // CFU codes, anything else is a branch not taken
    localparam logic [4:0] CFU_TAKEN  = 5'b00001;
    localparam logic [4:0] CFU_JALI   = 5'b00010;
    localparam logic [4:0] CFU_JALR   = 5'b00011;
    localparam logic [4:0] CFU_EBREAK = 5'b00100;
    localparam logic [4:0] CFU_ECALL  = 5'b00101;
    localparam logic [4:0] CFU_MRET   = 5'b00110;

    typedef struct packed {
        logic       spare;                        // Unused top bit
        logic [3:0] flags;                        // Read, write, set, clear
    } uop_csr_t;

    // One micro-op word, flags for CSR and LSU, a code for the CFU
    typedef union packed {
        uop_csr_t   csr;                          // Flag view
        logic [4:0] code;                         // Coded view
    } uop_t;

    //----------------------------------------------------------------------
    // Machine-mode CSRs and trap causes
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;

    localparam logic [5:0] CAUSE_EBREAK = 6'd3;
    localparam logic [5:0] CAUSE_ECALL  = 6'd11;
    localparam logic [5:0] CAUSE_INT    = {1'b1, 5'd11};  // External interrupt

endpackage

// ==== logic/frv_pipeline_register.sv ====
//--------------------------------------------------------------------------
// Stage 3 to stage 4 pipeline register
// Holds one instruction, reloads only when stage 4 is empty or progresses
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module frv_pipeline_register (
    input  logic                 g_clk,           // Global clock
    input  logic                 g_resetn,        // Sync reset, active low
    input  logic [4:0]           s3_rd,           // Destination register
    input  logic [frv_pkg::XL:0] s3_opr_a,        // Operand A
    input  logic [frv_pkg::XL:0] s3_opr_b,        // Operand B
    input  logic [31:0]          s3_pc,           // Program counter
    input  frv_pkg::uop_t        s3_uop,          // Micro-op
    input  logic [4:0]           s3_fu,           // Functional unit, one-hot
    input  logic                 s3_trap,         // Interrupt on this instr
    input  logic [31:0]          s3_instr,        // Instruction word
    input  logic                 s3_valid,        // Stage 3 output valid
    output logic                 s3_busy,         // Stage 3 must hold
    input  logic                 s4_busy,         // Writeback stalled
    output logic [4:0]           s4_rd,
    output logic [frv_pkg::XL:0] s4_opr_a,
    output logic [frv_pkg::XL:0] s4_opr_b,
    output logic [31:0]          s4_pc,
    output frv_pkg::uop_t        s4_uop,
    output logic [4:0]           s4_fu,
    output logic                 s4_trap,
    output logic [31:0]          s4_instr,
    output logic                 s4_valid
);
    logic load;

    assign s3_busy = s4_valid && s4_busy;         // Full and not moving
    assign load    = !s4_valid || !s4_busy;       // Empty or progressing

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            s4_valid <= 1'b0;
        end else if (load) begin
            s4_valid <= s3_valid;                 // Bubble when not valid
        end
    end

    // Payload, no reset
    always_ff @(posedge g_clk) begin
        if (load) begin
            s4_rd    <= s3_rd;
            s4_opr_a <= s3_opr_a;
            s4_opr_b <= s3_opr_b;
            s4_pc    <= s3_pc;
            s4_uop   <= s3_uop;
            s4_fu    <= s3_fu;
            s4_trap  <= s3_trap;
            s4_instr <= s3_instr;
        end
    end

endmodule

// ==== logic/frv_pipeline_writeback.sv ====
//--------------------------------------------------------------------------
// Writeback stage
// Retires one instruction: GPR write data select, CSR access, control-flow
// requests held until acknowledged, traps, forwarding and trace
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module frv_pipeline_writeback (
    input  logic                 g_clk,           // Global clock
    input  logic                 g_resetn,        // Sync reset, active low
    input  logic [4:0]           s4_rd,
    input  logic [frv_pkg::XL:0] s4_opr_a,        // Result or jump target
    input  logic [frv_pkg::XL:0] s4_opr_b,        // Link value or CSR addr
    input  logic [31:0]          s4_pc,
    input  frv_pkg::uop_t        s4_uop,
    input  logic [4:0]           s4_fu,
    input  logic                 s4_trap,         // Interrupt taken here
    input  logic [31:0]          s4_instr,
    input  logic                 s4_valid,
    output logic                 s4_busy,         // Stalled on control flow
    output logic [4:0]           fwd_s4_rd,
    output logic [frv_pkg::XL:0] fwd_s4_wdata,
    output logic                 fwd_s4_csr,
    output logic                 gpr_wen,
    output logic [4:0]           gpr_rd,
    output logic [frv_pkg::XL:0] gpr_wdata,
    output logic                 trap_cpu,        // ECALL or EBREAK
    output logic                 trap_int,        // Interrupt
    output logic [5:0]           trap_cause,
    output logic [frv_pkg::XL:0] trap_pc,
    input  logic [frv_pkg::XL:0] csr_mepc,
    input  logic [frv_pkg::XL:0] csr_mtvec,
    output logic                 csr_en,
    output logic                 csr_wr,
    output logic                 csr_wr_set,
    output logic                 csr_wr_clr,
    output logic [11:0]          csr_addr,
    output logic [frv_pkg::XL:0] csr_wdata,
    input  logic [frv_pkg::XL:0] csr_rdata,
    output logic [frv_pkg::XL:0] trs_pc,
    output logic [31:0]          trs_instr,
    output logic                 trs_valid,
    output logic                 cf_req,          // Level, held until ack
    output logic [frv_pkg::XL:0] cf_target,
    input  logic                 cf_ack
);
    import frv_pkg::*;

    logic fu_alu, fu_mul, fu_lsu, fu_cfu, fu_csr;
    logic cfu_taken, cfu_jump, cfu_ecall, cfu_ebreak, cfu_mret;
    logic cf_need, cfu_done, pipe_progress;
    logic wen_alu, wen_lsu, wen_csr, wen_cfu;

    //----------------------------------------------------------------------
    // Decode
    assign fu_alu = s4_fu[P_FU_ALU];
    assign fu_mul = s4_fu[P_FU_MUL];
    assign fu_lsu = s4_fu[P_FU_LSU];
    assign fu_cfu = s4_fu[P_FU_CFU];
    assign fu_csr = s4_fu[P_FU_CSR];

    assign cfu_taken  = fu_cfu && (s4_uop.code == CFU_TAKEN);
    assign cfu_jump   = fu_cfu && (s4_uop.code == CFU_JALI || s4_uop.code == CFU_JALR);
    assign cfu_ecall  = fu_cfu && (s4_uop.code == CFU_ECALL);
    assign cfu_ebreak = fu_cfu && (s4_uop.code == CFU_EBREAK);
    assign cfu_mret   = fu_cfu && (s4_uop.code == CFU_MRET);

    //----------------------------------------------------------------------
    // Control flow and stall
    assign cf_need = s4_valid && (cfu_taken || cfu_jump || cfu_ecall ||
                                  cfu_ebreak || cfu_mret || s4_trap);
    assign cf_req  = cf_need && !cfu_done;        // Not raised twice
    assign s4_busy = cf_need && !(cfu_done || cf_ack);
    assign pipe_progress = s4_valid && !s4_busy;  // Retires this cycle

    always_comb begin
        if (s4_trap || cfu_ecall || cfu_ebreak) begin
            cf_target = csr_mtvec;                // Trap vector
        end else if (cfu_mret) begin
            cf_target = csr_mepc;                 // Return from trap
        end else begin
            cf_target = s4_opr_a;                 // Branch or jump target
        end
    end

    // Acked but instruction still held
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cfu_done <= 1'b0;
        end else begin
            cfu_done <= !pipe_progress && (cfu_done || (cf_req && cf_ack));
        end
    end

    //----------------------------------------------------------------------
    // GPR writeback, interrupt suppresses it
    assign wen_alu = fu_alu || fu_mul;
    assign wen_lsu = fu_lsu && s4_uop.csr.flags[LSU_LOAD];
    assign wen_csr = fu_csr && s4_uop.csr.flags[CSR_READ];
    assign wen_cfu = cfu_jump;                    // Link value

    assign gpr_wen = pipe_progress && !s4_trap &&
                     (wen_alu || wen_lsu || wen_csr || wen_cfu);
    assign gpr_rd  = s4_rd;

    always_comb begin
        if (wen_csr) begin
            gpr_wdata = csr_rdata;
        end else if (wen_cfu) begin
            gpr_wdata = s4_opr_b;
        end else begin
            gpr_wdata = s4_opr_a;                 // ALU, MUL and load
        end
    end

    assign fwd_s4_rd    = s4_rd;
    assign fwd_s4_wdata = gpr_wdata;
    assign fwd_s4_csr   = s4_valid && fu_csr;

    //----------------------------------------------------------------------
    // CSR access, traps and trace
    assign csr_en     = pipe_progress && fu_csr && !s4_trap;
    assign csr_wr     = csr_en && s4_uop.csr.flags[CSR_WRITE];
    assign csr_wr_set = csr_en && s4_uop.csr.flags[CSR_SET];
    assign csr_wr_clr = csr_en && s4_uop.csr.flags[CSR_CLEAR];
    assign csr_addr   = s4_opr_b[11:0];
    assign csr_wdata  = s4_opr_a;

    assign trap_int   = pipe_progress && s4_trap;
    assign trap_cpu   = pipe_progress && !s4_trap && (cfu_ecall || cfu_ebreak);
    assign trap_cause = s4_trap ? CAUSE_INT : (cfu_ecall ? CAUSE_ECALL : CAUSE_EBREAK);
    assign trap_pc    = s4_pc;

    assign trs_pc    = s4_pc;
    assign trs_instr = s4_instr;
    assign trs_valid = pipe_progress;             // One pulse per retire

endmodule

// ==== logic/frv_csrs.sv ====
//--------------------------------------------------------------------------
// Machine-mode CSR file
// mepc, mtvec, mcause and mscratch with write, set and clear access;
// trap entry captures mepc and mcause ahead of any CSR write
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module frv_csrs (
    input  logic                 g_clk,           // Global clock
    input  logic                 g_resetn,        // Sync reset, active low
    input  logic                 csr_en,          // Access this cycle
    input  logic                 csr_wr,          // Plain write
    input  logic                 csr_wr_set,      // Set bits
    input  logic                 csr_wr_clr,      // Clear bits
    input  logic [11:0]          csr_addr,
    input  logic [frv_pkg::XL:0] csr_wdata,
    output logic [frv_pkg::XL:0] csr_rdata,
    input  logic                 trap_cpu,
    input  logic                 trap_int,
    input  logic [5:0]           trap_cause,
    input  logic [frv_pkg::XL:0] trap_pc,
    output logic [frv_pkg::XL:0] csr_mepc,
    output logic [frv_pkg::XL:0] csr_mtvec
);
    import frv_pkg::*;

    logic [XL:0] mepc, mtvec, mcause, mscratch;
    logic [XL:0] new_val;
    logic        trap, csr_we;

    always_comb begin
        case (csr_addr)
            CSR_MEPC:     csr_rdata = mepc;
            CSR_MTVEC:    csr_rdata = mtvec;
            CSR_MCAUSE:   csr_rdata = mcause;
            CSR_MSCRATCH: csr_rdata = mscratch;
            default:      csr_rdata = '0;         // Unknown reads zero
        endcase
    end

    // Update value from the current contents
    always_comb begin
        if (csr_wr) begin
            new_val = csr_wdata;
        end else if (csr_wr_set) begin
            new_val = csr_rdata | csr_wdata;
        end else begin
            new_val = csr_rdata & ~csr_wdata;
        end
    end

    assign trap   = trap_cpu || trap_int;
    assign csr_we = csr_en && (csr_wr || csr_wr_set || csr_wr_clr) && !trap;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mepc     <= '0;
            mtvec    <= '0;
            mcause   <= '0;
            mscratch <= '0;
        end else if (trap) begin
            mepc   <= trap_pc;                    // Trapped instruction
            mcause <= {{(XLEN - 6){1'b0}}, trap_cause};
        end else if (csr_we) begin
            case (csr_addr)
                CSR_MEPC:     mepc     <= new_val;
                CSR_MTVEC:    mtvec    <= new_val;
                CSR_MCAUSE:   mcause   <= new_val;
                CSR_MSCRATCH: mscratch <= new_val;
                default:      ;                   // Unknown, ignored
            endcase
        end
    end

    assign csr_mepc  = mepc;
    assign csr_mtvec = mtvec;

endmodule

// ==== logic/frv_gprs.sv ====
//--------------------------------------------------------------------------
// General purpose register file
// 32 x 32 bits, x0 hard zero, one write port, one combinational read port
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module frv_gprs (
    input  logic                 g_clk,           // Global clock
    input  logic                 g_resetn,        // Sync reset, active low
    input  logic                 gpr_wen,         // Write enable
    input  logic [4:0]           gpr_rd,          // Write address
    input  logic [frv_pkg::XL:0] gpr_wdata,       // Write data
    input  logic [4:0]           rs1_addr,        // Read address
    output logic [frv_pkg::XL:0] rs1_data         // Read data
);
    import frv_pkg::*;

    logic [XL:0] regs [1:31];                     // No storage for x0

    // No writes while reset held
    always_ff @(posedge g_clk) begin
        if (g_resetn && gpr_wen && (gpr_rd != 5'd0)) begin
            regs[gpr_rd] <= gpr_wdata;
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];

endmodule

// ==== logic/frv_core_backend.sv ====
//--------------------------------------------------------------------------
// Core back end
// Stage register, writeback stage, CSR file and GPR file
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module frv_core_backend (
    input  logic                 g_clk,           // Global clock
    input  logic                 g_resetn,        // Sync reset, active low
    input  logic [4:0]           s3_rd,
    input  logic [frv_pkg::XL:0] s3_opr_a,
    input  logic [frv_pkg::XL:0] s3_opr_b,
    input  logic [31:0]          s3_pc,
    input  frv_pkg::uop_t        s3_uop,
    input  logic [4:0]           s3_fu,
    input  logic                 s3_trap,
    input  logic [31:0]          s3_instr,
    input  logic                 s3_valid,
    output logic                 s3_busy,
    output logic                 cf_req,
    output logic [frv_pkg::XL:0] cf_target,
    input  logic                 cf_ack,
    output logic [4:0]           fwd_s4_rd,
    output logic [frv_pkg::XL:0] fwd_s4_wdata,
    output logic                 fwd_s4_csr,
    output logic [frv_pkg::XL:0] trs_pc,
    output logic [31:0]          trs_instr,
    output logic                 trs_valid,
    input  logic [4:0]           rs1_addr,
    output logic [frv_pkg::XL:0] rs1_data
);
    import frv_pkg::*;

    // Stage 4 payload
    logic [4:0]  s4_rd;
    logic [XL:0] s4_opr_a, s4_opr_b;
    logic [31:0] s4_pc, s4_instr;
    uop_t        s4_uop;
    logic [4:0]  s4_fu;
    logic        s4_trap, s4_valid, s4_busy;

    // Writeback to register files
    logic        gpr_wen;
    logic [4:0]  gpr_rd;
    logic [XL:0] gpr_wdata;
    logic        csr_en, csr_wr, csr_wr_set, csr_wr_clr;
    logic [11:0] csr_addr;
    logic [XL:0] csr_wdata, csr_rdata, csr_mepc, csr_mtvec;
    logic        trap_cpu, trap_int;
    logic [5:0]  trap_cause;
    logic [XL:0] trap_pc;

    frv_pipeline_register u_s4_reg (.*);

    frv_pipeline_writeback u_writeback (.*);

    frv_csrs u_csrs (.*);

    frv_gprs u_gprs (.*);

endmodule

// ==== testbench/frv_backend_asserts.sv ====
//--------------------------------------------------------------------------
// Writeback stage assertions
// Control-flow request hold, GPR write port quiet and held while stalled,
// quiet after reset
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module frv_backend_asserts (
    input logic                 g_clk,
    input logic                 g_resetn,
    input logic                 cf_req,
    input logic                 cf_ack,
    input logic [frv_pkg::XL:0] cf_target,
    input logic                 s4_busy,
    input logic                 gpr_wen,
    input logic [4:0]           gpr_rd,
    input logic [frv_pkg::XL:0] gpr_wdata
);
    // Request and target held until acknowledged
    cf_req_held: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cf_req && !cf_ack |=> cf_req && $stable(cf_target))
        else $error("cf_req dropped or cf_target changed before cf_ack");

    // Stalled instr writes nothing and keeps its write port
    no_wen_busy: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s4_busy |=> !$past(gpr_wen) && $stable(gpr_rd) && $stable(gpr_wdata))
        else $error("gpr_wen high or GPR write port changed while stalled");

    no_req_after_reset: assert property (@(posedge g_clk) !g_resetn |=> !cf_req)
        else $error("cf_req high in the cycle after reset");

endmodule

bind frv_pipeline_writeback frv_backend_asserts u_asserts (
    .g_clk     (g_clk),
    .g_resetn  (g_resetn),
    .cf_req    (cf_req),
    .cf_ack    (cf_ack),
    .cf_target (cf_target),
    .s4_busy   (s4_busy),
    .gpr_wen   (gpr_wen),
    .gpr_rd    (gpr_rd),
    .gpr_wdata (gpr_wdata)
);

// ==== testbench/frv_backend_tb.sv ====
//--------------------------------------------------------------------------
// Back-end testbench
// Random instructions into stage 3 with random cf_ack, checked against a
// model of retirement order, GPRs, CSRs, traps and forwarding
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module frv_backend_tb;
    import frv_pkg::*;

    localparam int N_INSTR    = 400;                // Instructions to retire
    localparam int MAX_CYCLES = N_INSTR * 8;        // Timeout limit

    typedef struct packed {
        logic [4:0]  rd;
        logic [XL:0] a;
        logic [XL:0] b;
        logic [31:0] pc;
        logic [4:0]  uop;
        logic [4:0]  fu;
        logic        trap;
        logic [31:0] instr;
    } instr_t;

    logic        g_clk, g_resetn;
    logic [4:0]  s3_rd, s3_fu, fwd_s4_rd, rs1_addr, last_rd;
    logic [XL:0] s3_opr_a, s3_opr_b, cf_target, fwd_s4_wdata, trs_pc, rs1_data;
    logic [31:0] s3_pc, s3_instr, trs_instr, rnd;
    uop_t        s3_uop;
    logic        s3_trap, s3_valid, s3_busy, cf_req, cf_ack, fwd_s4_csr, trs_valid;

    instr_t      pipe_q[$];                         // Accepted, not retired
    instr_t      cur, nxt;
    logic [XL:0] gpr_m [0:31];                      // Model GPRs
    logic        gpr_known [0:31];                  // Written at least once
    logic [XL:0] m_mepc, m_mtvec, m_mcause, m_mscratch;
    logic        retire, pending, read_back;
    integer      seed, retired;
    integer      cycles = 0;

    frv_core_backend dut0 (.*);

    initial begin
        g_clk = 1'b0;
        forever #50 g_clk = ~g_clk;                 // 100 ns period
    end

    always @(posedge g_clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: %0d of %0d instructions retired", retired, N_INSTR);
            $display("Done: errors found");
            $fatal(1, "Run exceeded the cycle limit");
        end
    end

    task automatic check_equal(input string what, input logic [XL:0] got,
                               input logic [XL:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "Mismatch");
        end
    endtask

    //----------------------------------------------------------------------
    // Reference model
    function automatic logic is_cfu(instr_t i, logic [4:0] code);
        return i.fu[P_FU_CFU] && (i.uop == code);
    endfunction

    function automatic logic needs_cf(instr_t i);
        return i.trap || is_cfu(i, CFU_TAKEN) || is_cfu(i, CFU_JALI) ||
               is_cfu(i, CFU_JALR) || is_cfu(i, CFU_EBREAK) ||
               is_cfu(i, CFU_ECALL) || is_cfu(i, CFU_MRET);
    endfunction

    function automatic logic [XL:0] target_of(instr_t i);
        if (i.trap || is_cfu(i, CFU_ECALL) || is_cfu(i, CFU_EBREAK)) begin
            return m_mtvec;                         // Trap entry
        end else if (is_cfu(i, CFU_MRET)) begin
            return m_mepc;
        end
        return i.a;                                 // Branch or jump target
    endfunction

    function automatic logic [XL:0] csr_value(logic [11:0] addr);
        case (addr)
            CSR_MEPC:     return m_mepc;
            CSR_MTVEC:    return m_mtvec;
            CSR_MCAUSE:   return m_mcause;
            CSR_MSCRATCH: return m_mscratch;
            default:      return '0;
        endcase
    endfunction

    function automatic logic writes_gpr(instr_t i);
        return !i.trap && (i.fu[P_FU_ALU] || i.fu[P_FU_MUL] ||
               (i.fu[P_FU_LSU] && i.uop[LSU_LOAD]) || (i.fu[P_FU_CSR] && i.uop[CSR_READ]) ||
               is_cfu(i, CFU_JALI) || is_cfu(i, CFU_JALR));
    endfunction

    function automatic logic [XL:0] result_of(instr_t i);
        if (i.fu[P_FU_CSR]) begin
            return csr_value(i.b[11:0]);            // Old CSR value
        end else if (i.fu[P_FU_CFU]) begin
            return i.b;                             // Link value
        end
        return i.a;
    endfunction

    task automatic retire_model(instr_t i);
        logic [XL:0] old, nv;
        if (writes_gpr(i) && i.rd != 5'd0) begin
            gpr_m[i.rd]     = result_of(i);
            gpr_known[i.rd] = 1'b1;
        end
        old = csr_value(i.b[11:0]);
        if (i.trap || is_cfu(i, CFU_ECALL) || is_cfu(i, CFU_EBREAK)) begin
            m_mepc   = i.pc;
            m_mcause = i.trap ? 32'(CAUSE_INT) :
                       (is_cfu(i, CFU_ECALL) ? 32'(CAUSE_ECALL) : 32'(CAUSE_EBREAK));
        end else if (i.fu[P_FU_CSR] && i.uop[3:1] != 3'd0) begin
            if (i.uop[CSR_WRITE]) begin
                nv = i.a;
            end else if (i.uop[CSR_SET]) begin
                nv = old | i.a;
            end else begin
                nv = old & ~i.a;
            end
            case (i.b[11:0])
                CSR_MEPC:     m_mepc     = nv;
                CSR_MTVEC:    m_mtvec    = nv;
                CSR_MCAUSE:   m_mcause   = nv;
                CSR_MSCRATCH: m_mscratch = nv;
                default:      ;                     // Unknown CSR ignored
            endcase
        end
    endtask

    //----------------------------------------------------------------------
    // Stimulus and per-cycle checks
    task automatic make_instr(output instr_t i);
        logic [31:0] r, r2;
        logic [11:0] addr;
        r  = $random(seed);
        r2 = $random(seed);
        i  = '0;
        i.rd    = r[4:0];
        i.trap  = (r[9:6] == 4'd0);                 // Interrupt one in 16
        i.a     = $random(seed);
        i.b     = $random(seed);
        i.pc    = {r2[31:2], 2'b00};
        i.instr = $random(seed);
        case (r[12:10])
            3'd1:       i.fu = 5'b00010;            // MUL
            3'd2: begin
                i.fu  = 5'b00100;                   // Load or store
                i.uop = r[17:13];
            end
            3'd3, 3'd4: begin
                i.fu  = 5'b01000;                   // Codes 0 and 7 not taken
                i.uop = {2'b00, r[15:13]};
            end
            3'd5, 3'd6: begin
                case (r[15:13])
                    3'd2, 3'd3: addr = CSR_MTVEC;
                    3'd4:       addr = CSR_MEPC;
                    3'd5:       addr = CSR_MCAUSE;
                    3'd6:       addr = 12'h7c0;     // Not implemented
                    default:    addr = CSR_MSCRATCH;
                endcase
                i.fu  = 5'b10000;
                i.b   = {r2[31:12], addr};
                i.uop = {r[19], r[17:16] == 2'd3, r[17:16] == 2'd2,
                         r[17:16] == 2'd1, r[18]};  // At most one update op
            end
            default:    i.fu = 5'b00001;            // ALU
        endcase
    endtask

    task automatic check_cycle();
        if (gpr_known[rs1_addr]) begin
            check_equal("rs1_data", rs1_data, gpr_m[rs1_addr]);
        end
        retire = 1'b0;
        if (pipe_q.size() != 0) begin
            cur = pipe_q[0];                        // Instruction in stage 4
            check_equal("fwd_s4_rd", 32'(fwd_s4_rd), 32'(cur.rd));
            check_equal("fwd_s4_csr", 32'(fwd_s4_csr), 32'(cur.fu[P_FU_CSR]));
            if (writes_gpr(cur)) begin
                check_equal("fwd_s4_wdata", fwd_s4_wdata, result_of(cur));
            end
            check_equal("cf_req", 32'(cf_req), 32'(needs_cf(cur)));
            if (needs_cf(cur)) begin
                check_equal("cf_target", cf_target, target_of(cur));
            end
            retire = !needs_cf(cur) || cf_ack;
        end else begin
            check_equal("cf_req", 32'(cf_req), 32'd0);
        end
        check_equal("trs_valid", 32'(trs_valid), 32'(retire));
        check_equal("s3_busy", 32'(s3_busy), 32'(pipe_q.size() != 0 && !retire));
        read_back = retire;
        if (retire) begin
            check_equal("trs_pc", trs_pc, cur.pc);
            check_equal("trs_instr", trs_instr, cur.instr);
            last_rd = cur.rd;                       // Read back next cycle
            retire_model(cur);
            void'(pipe_q.pop_front());
            retired++;
        end
        if (s3_valid && !s3_busy) begin
            pipe_q.push_back(nxt);
        end
        pending = s3_valid && s3_busy;              // Stage 3 holds
    endtask

    initial begin
        seed       = 91719;
        g_resetn   = 1'b0;
        s3_valid   = 1'b0;
        s3_rd      = '0;
        s3_opr_a   = '0;
        s3_opr_b   = '0;
        s3_pc      = '0;
        s3_uop     = '0;
        s3_fu      = '0;
        s3_trap    = 1'b0;
        s3_instr   = '0;
        cf_ack     = 1'b0;
        rs1_addr   = '0;
        gpr_m      = '{default: '0};
        gpr_known  = '{default: 1'b0};
        gpr_known[0] = 1'b1;                        // x0 reads zero
        m_mepc     = '0;
        m_mtvec    = '0;
        m_mcause   = '0;
        m_mscratch = '0;
        pending    = 1'b0;
        read_back  = 1'b0;
        last_rd    = '0;
        retired    = 0;
        repeat (2) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;
        while (retired < N_INSTR) begin
            rnd = $random(seed);
            if (!pending) begin
                make_instr(nxt);
                s3_valid = (rnd[2:1] != 2'b00);     // Bubble one time in four
                s3_rd    = nxt.rd;
                s3_opr_a = nxt.a;
                s3_opr_b = nxt.b;
                s3_pc    = nxt.pc;
                s3_uop   = uop_t'(nxt.uop);
                s3_fu    = nxt.fu;
                s3_trap  = nxt.trap;
                s3_instr = nxt.instr;
            end
            cf_ack   = rnd[0];
            rs1_addr = read_back ? last_rd : rnd[7:3];
            #40;                                    // Settled, before posedge
            check_cycle();
            @(negedge g_clk);
        end
        s3_valid = 1'b0;
        rs1_addr = last_rd;                         // Last retirement
        #40;
        if (gpr_known[rs1_addr]) begin
            check_equal("rs1_data", rs1_data, gpr_m[rs1_addr]);
        end
        $display("Retired %0d instructions in %0d cycles", retired, cycles);
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== files.f ====
logic/frv_pkg.sv
logic/frv_pipeline_register.sv
logic/frv_pipeline_writeback.sv
logic/frv_csrs.sv
logic/frv_gprs.sv
logic/frv_core_backend.sv
testbench/frv_backend_asserts.sv
testbench/frv_backend_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the back-end testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module frv_backend_tb -f files.f -o frv_backend_sim
out=$(./obj_dir/frv_backend_sim 2>&1) || true
echo "$out"
if grep -qx "Done: no errors" <<< "$out"; then
    exit 0
else
    exit 1
fi
